// ==== Bender.yml ====
package:
  name: decode_stage

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/rv_isa_pkg.sv
      - hdl/decode_ctrl_pkg.sv
      - hdl/fetch_hold_buffer.sv
      - hdl/inst_classifier.sv
      - hdl/imm_generator.sv
      - hdl/issue_control.sv
      - hdl/decode_stage.sv
  - target: test
    include_dirs:
      - hdl
      - tests
    files:
      - tests/decode_stage_tb.sv

// ==== hdl/decode_ctrl_pkg.sv ====
// decode to execute control types
`default_nettype none

`include "decode_macros.svh"

package decode_ctrl_pkg;

	typedef enum logic [`ALU_OP_W-1:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_SLL,
		ALU_SLT,
		ALU_SLTU,
		ALU_XOR,
		ALU_SRL,
		ALU_SRA,
		ALU_OR,
		ALU_AND,
		ALU_SEQ,
		ALU_SNE,
		ALU_SGE,
		ALU_SGEU
	} alu_op_t;

	typedef enum logic [`MEM_SIZE_W-1:0] {
		MEM_BYTE,
		MEM_BYTE_U,
		MEM_HALF,
		MEM_HALF_U,
		MEM_WORD
	} mem_size_t;

	typedef enum logic [`IMM_SEL_W-1:0] {IMM_U, IMM_J, IMM_I, IMM_B, IMM_S, IMM_Z} imm_sel_t;

	// upper covers lui and auipc, execute adds the pc for auipc (inst bit 5 low)
	typedef enum logic [`RD_SRC_W-1:0] {RD_ALU, RD_UPPER, RD_PC_PLUS} rd_src_t;

	typedef enum logic [`CSR_OP_W-1:0] {CSR_NONE, CSR_WRITE, CSR_SET, CSR_CLEAR} csr_op_t;

endpackage

`default_nettype wire

// ==== hdl/decode_macros.svh ====
// decode stage width and encoding macros
`ifndef DECODE_MACROS_SVH
`define DECODE_MACROS_SVH

// data and address width
`define XLEN 32

// register file index width
`define REG_ADDR_W 5

// csr address field width
`define CSR_ADDR_W 12

// instruction field widths
`define OPCODE_W 5
`define FUNCT3_W 3
`define FUNCT7_W 7

// addi x0, x0, 0
`define INST_NOP 32'h0000_0013

// control field widths seen by execute
`define ALU_OP_W 4
`define MEM_SIZE_W 3
`define IMM_SEL_W 3
`define RD_SRC_W 2
`define CSR_OP_W 2

`endif

// ==== hdl/decode_stage.sv ====
// rv32i decode stage
`timescale 1ns/1ps
`default_nettype none

`include "decode_macros.svh"

module decode_stage
	import decode_ctrl_pkg::*;
(
	input  logic                   clk,
	input  logic                   rstn,
	input  logic                   stall,
	input  logic                   flush,
	input  logic                   if_valid,
	input  logic [`XLEN-1:0]       if_pc,
	input  logic [`XLEN-1:0]       if_pc_plus,
	input  logic                   imem_valid,
	input  logic [`XLEN-1:0]       imem_data,
	input  logic                   lsu_mem_re,
	input  logic [`REG_ADDR_W-1:0] lsu_rd,
	output logic                   ex_valid,
	output logic [`XLEN-1:0]       ex_inst,
	output logic                   ex_rf_we,
	output logic                   ex_mem_we,
	output logic                   ex_mem_re,
	output logic                   ex_branch,
	output logic                   ex_jump,
	output logic                   ex_csr_we,
	output logic                   ex_csr_re,
	output logic [`XLEN-1:0]       ex_pc,
	output logic [`XLEN-1:0]       ex_pc_plus,
	output logic [`REG_ADDR_W-1:0] ex_rs1,
	output logic [`REG_ADDR_W-1:0] ex_rs2,
	output logic [`REG_ADDR_W-1:0] ex_rd,
	output logic [`CSR_ADDR_W-1:0] ex_csr_addr,
	output logic [`XLEN-1:0]       ex_imm,
	output alu_op_t                ex_alu_op,
	output logic                   ex_alu_op2_imm,
	output rd_src_t                ex_rd_src,
	output logic                   ex_rd_from_mem,
	output mem_size_t              ex_mem_size,
	output logic                   ex_jalr,
	output logic                   hazard
);
	logic             id_valid;
	logic [`XLEN-1:0] id_inst;
	logic             inst_present;
	imm_sel_t         imm_sel;
	csr_op_t          csr_op;
	logic             csr_uses_imm;
	logic             rf_we_raw;
	logic             mem_we_raw;
	logic             mem_re_raw;
	logic             branch_raw;
	logic             jump_raw;
	logic             uses_rs2;
	logic             is_fence;

	fetch_hold_buffer fetch_hold_buffer_i (
		.clk          (clk),
		.rstn         (rstn),
		.stall        (stall),
		.if_valid     (if_valid),
		.if_pc        (if_pc),
		.if_pc_plus   (if_pc_plus),
		.imem_valid   (imem_valid),
		.imem_data    (imem_data),
		.id_valid     (id_valid),
		.id_pc        (ex_pc),
		.id_pc_plus   (ex_pc_plus),
		.id_inst      (id_inst),
		.inst_present (inst_present)
	);

	inst_classifier inst_classifier_i (
		.id_valid     (id_valid),
		.id_inst      (id_inst),
		.imm_sel      (imm_sel),
		.csr_op       (csr_op),
		.csr_uses_imm (csr_uses_imm),
		.alu_op       (ex_alu_op),
		.alu_op2_imm  (ex_alu_op2_imm),
		.rd_src       (ex_rd_src),
		.rd_from_mem  (ex_rd_from_mem),
		.mem_size     (ex_mem_size),
		.rf_we_raw    (rf_we_raw),
		.mem_we_raw   (mem_we_raw),
		.mem_re_raw   (mem_re_raw),
		.branch_raw   (branch_raw),
		.jump_raw     (jump_raw),
		.jalr         (ex_jalr),
		.uses_rs2     (uses_rs2),
		.is_fence     (is_fence)
	);

	imm_generator imm_generator_i (
		.id_inst (id_inst),
		.imm_sel (imm_sel),
		.csr_op  (csr_op),
		.imm     (ex_imm)
	);

	issue_control issue_control_i (
		.flush        (flush),
		.id_valid     (id_valid),
		.inst_present (inst_present),
		.id_inst      (id_inst),
		.is_fence     (is_fence),
		.csr_op       (csr_op),
		.csr_uses_imm (csr_uses_imm),
		.rf_we_raw    (rf_we_raw),
		.mem_we_raw   (mem_we_raw),
		.mem_re_raw   (mem_re_raw),
		.branch_raw   (branch_raw),
		.jump_raw     (jump_raw),
		.uses_rs2     (uses_rs2),
		.lsu_mem_re   (lsu_mem_re),
		.lsu_rd       (lsu_rd),
		.ex_valid     (ex_valid),
		.ex_inst      (ex_inst),
		.ex_rf_we     (ex_rf_we),
		.ex_mem_we    (ex_mem_we),
		.ex_mem_re    (ex_mem_re),
		.ex_branch    (ex_branch),
		.ex_jump      (ex_jump),
		.ex_csr_we    (ex_csr_we),
		.ex_csr_re    (ex_csr_re),
		.hazard       (hazard)
	);

	// register and csr indices for forwarding and file reads
	assign ex_rs1      = id_inst[19:15];
	assign ex_rs2      = id_inst[24:20];
	assign ex_rd       = id_inst[11:7];
	assign ex_csr_addr = id_inst[31:20];

endmodule

`default_nettype wire

// ==== hdl/fetch_hold_buffer.sv ====
// decode stage register and instruction hold buffer
`timescale 1ns/1ps
`default_nettype none

`include "decode_macros.svh"

module fetch_hold_buffer (
	input  logic             clk,
	input  logic             rstn,
	input  logic             stall,
	input  logic             if_valid,
	input  logic [`XLEN-1:0] if_pc,
	input  logic [`XLEN-1:0] if_pc_plus,
	input  logic             imem_valid,
	input  logic [`XLEN-1:0] imem_data,
	output logic             id_valid,
	output logic [`XLEN-1:0] id_pc,
	output logic [`XLEN-1:0] id_pc_plus,
	output logic [`XLEN-1:0] id_inst,
	output logic             inst_present
);
	logic             hold;
	logic             hold_set;
	logic [`XLEN-1:0] buf_inst;

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			id_valid   <= 1'b0;
			id_pc      <= '0;
			id_pc_plus <= '0;
		end else if (!stall) begin
			id_valid   <= if_valid;
			id_pc      <= if_pc;
			id_pc_plus <= if_pc_plus;
		end
	end

	// memory answers only once, so grab the word the first stalled cycle
	assign hold_set = id_valid && imem_valid && stall && !hold;

	// hold doubles as the valid flag of the buffered word
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			hold <= 1'b0;
		end else if (hold_set) begin
			hold <= 1'b1;
		end else if (!stall) begin
			hold <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (hold_set) begin
			buf_inst <= imem_data;
		end
	end

	// buffered copy wins until the edge after stall drops
	assign id_inst      = hold ? buf_inst : imem_data;
	assign inst_present = hold || imem_valid;

	a_hold_needs_stall: assert property (
		@(posedge clk) disable iff (!rstn)
		$rose(hold) |-> $past(stall)
	) else $error("hold buffer filled without a stall");

endmodule

`default_nettype wire

// ==== hdl/imm_generator.sv ====
// immediate generator
`timescale 1ns/1ps
`default_nettype none

`include "decode_macros.svh"

module imm_generator
	import decode_ctrl_pkg::*;
(
	input  logic [`XLEN-1:0] id_inst,
	input  imm_sel_t         imm_sel,
	input  csr_op_t          csr_op,
	output logic [`XLEN-1:0] imm
);
	logic [`XLEN-1:0] imm_u;
	logic [`XLEN-1:0] imm_j;
	logic [`XLEN-1:0] imm_i;
	logic [`XLEN-1:0] imm_b;
	logic [`XLEN-1:0] imm_s;
	logic [`XLEN-1:0] imm_z;

	assign imm_u = {id_inst[31:12], 12'b0};
	assign imm_j = {{12{id_inst[31]}}, id_inst[19:12], id_inst[20], id_inst[30:21], 1'b0};
	assign imm_i = {{21{id_inst[31]}}, id_inst[30:20]};
	assign imm_b = {{20{id_inst[31]}}, id_inst[7], id_inst[30:25], id_inst[11:8], 1'b0};
	assign imm_s = {{21{id_inst[31]}}, id_inst[30:25], id_inst[11:7]};

	// uimm sits in the rs1 field, clear turns it into an and-mask
	always_comb begin
		imm_z = {{(`XLEN - `REG_ADDR_W){1'b0}}, id_inst[19:15]};
		if (csr_op == CSR_CLEAR) begin
			imm_z = ~imm_z;
		end
	end

	always_comb begin
		case (imm_sel)
			IMM_J:   imm = imm_j;
			IMM_I:   imm = imm_i;
			IMM_B:   imm = imm_b;
			IMM_S:   imm = imm_s;
			IMM_Z:   imm = imm_z;
			default: imm = imm_u;
		endcase
	end

endmodule

`default_nettype wire

// ==== hdl/inst_classifier.sv ====
// rv32i instruction classifier
`timescale 1ns/1ps
`default_nettype none

`include "decode_macros.svh"

module inst_classifier
	import rv_isa_pkg::*;
	import decode_ctrl_pkg::*;
(
	input  logic             id_valid,
	input  logic [`XLEN-1:0] id_inst,
	output imm_sel_t         imm_sel,
	output csr_op_t          csr_op,
	output logic             csr_uses_imm,
	output alu_op_t          alu_op,
	output logic             alu_op2_imm,
	output rd_src_t          rd_src,
	output logic             rd_from_mem,
	output mem_size_t        mem_size,
	output logic             rf_we_raw,
	output logic             mem_we_raw,
	output logic             mem_re_raw,
	output logic             branch_raw,
	output logic             jump_raw,
	output logic             jalr,
	output logic             uses_rs2,
	output logic             is_fence
);
	opcode_t              opcode;
	funct3_t              funct3;
	logic [`FUNCT7_W-1:0] funct7;
	logic is_lui, is_auipc, is_jal, is_jalr, is_branch, is_load;
	logic is_store, is_op_imm, is_op, is_misc_mem, is_system, is_csr;

	assign opcode = opcode_t'(id_inst[6:2]);
	assign funct3 = id_inst[14:12];
	assign funct7 = id_inst[31:25];

	// class flags, only for a valid stage
	assign is_lui      = id_valid && (opcode == OPC_LUI);
	assign is_auipc    = id_valid && (opcode == OPC_AUIPC);
	assign is_jal      = id_valid && (opcode == OPC_JAL);
	assign is_jalr     = id_valid && (opcode == OPC_JALR);
	assign is_branch   = id_valid && (opcode == OPC_BRANCH);
	assign is_load     = id_valid && (opcode == OPC_LOAD);
	assign is_store    = id_valid && (opcode == OPC_STORE);
	assign is_op_imm   = id_valid && (opcode == OPC_OP_IMM);
	assign is_op       = id_valid && (opcode == OPC_OP);
	assign is_misc_mem = id_valid && (opcode == OPC_MISC_MEM);
	assign is_system   = id_valid && (opcode == OPC_SYSTEM);

	assign is_fence = is_misc_mem && (funct3 == F3_FENCE);

	// funct3[1:0] picks the csr kind, 00 is ecall/ebreak territory
	always_comb begin
		case (funct3[1:0])
			2'b01:   csr_op = is_system ? CSR_WRITE : CSR_NONE;
			2'b10:   csr_op = is_system ? CSR_SET : CSR_NONE;
			2'b11:   csr_op = is_system ? CSR_CLEAR : CSR_NONE;
			default: csr_op = CSR_NONE;
		endcase
	end

	assign is_csr       = (csr_op != CSR_NONE);
	assign csr_uses_imm = is_csr && funct3[2];

	always_comb begin
		alu_op = ALU_ADD;
		if (is_branch) begin
			case (funct3)
				F3_BEQ:  alu_op = ALU_SEQ;
				F3_BNE:  alu_op = ALU_SNE;
				F3_BLT:  alu_op = ALU_SLT;
				F3_BGE:  alu_op = ALU_SGE;
				F3_BLTU: alu_op = ALU_SLTU;
				F3_BGEU: alu_op = ALU_SGEU;
				default: alu_op = ALU_ADD;
			endcase
		end else if (is_op || is_op_imm) begin
			case (funct3)
				F3_ADD:  alu_op = (is_op && funct7 == FUNCT7_ALT) ? ALU_SUB : ALU_ADD;
				F3_SLL:  alu_op = ALU_SLL;
				F3_SLT:  alu_op = ALU_SLT;
				F3_SLTU: alu_op = ALU_SLTU;
				F3_XOR:  alu_op = ALU_XOR;
				F3_SR:   alu_op = (funct7 == FUNCT7_ALT) ? ALU_SRA : ALU_SRL;
				F3_OR:   alu_op = ALU_OR;
				default: alu_op = ALU_AND;
			endcase
		end else if (csr_op == CSR_SET) begin
			alu_op = ALU_OR;
		end else if (csr_op == CSR_CLEAR) begin
			// operand arrives already inverted
			alu_op = ALU_AND;
		end
	end

	always_comb begin
		mem_size = MEM_BYTE;
		if (is_load || is_store) begin
			case (funct3)
				F3_BU:   mem_size = MEM_BYTE_U;
				F3_H:    mem_size = MEM_HALF;
				F3_HU:   mem_size = MEM_HALF_U;
				F3_W:    mem_size = MEM_WORD;
				default: mem_size = MEM_BYTE;
			endcase
		end
	end

	always_comb begin
		if (is_jal)
			imm_sel = IMM_J;
		else if (is_jalr || is_load || is_op_imm)
			imm_sel = IMM_I;
		else if (is_branch)
			imm_sel = IMM_B;
		else if (is_store)
			imm_sel = IMM_S;
		else if (is_csr)
			imm_sel = IMM_Z;
		else
			imm_sel = IMM_U;
	end

	assign rd_src = (is_lui || is_auipc) ? RD_UPPER :
	                (is_jal || is_jalr)  ? RD_PC_PLUS : RD_ALU;

	assign alu_op2_imm = is_jalr || is_load || is_store || is_op_imm || is_csr;
	assign rd_from_mem = is_load;
	assign rf_we_raw   = is_lui || is_auipc || is_jal || is_jalr || is_load ||
	                     is_op_imm || is_op || is_csr;
	assign mem_we_raw  = is_store;
	assign mem_re_raw  = is_load;
	assign branch_raw  = is_branch;
	assign jump_raw    = is_jal || is_jalr;
	assign jalr        = is_jalr;
	assign uses_rs2    = is_branch || is_op;

	always_comb begin
		a_one_class: assert final ($onehot0({is_lui, is_auipc, is_jal, is_jalr, is_branch,
			is_load, is_store, is_op_imm, is_op, is_misc_mem, is_system}))
		else $error("more than one instruction class active");
	end

endmodule

`default_nettype wire

// ==== hdl/issue_control.sv ====
// decode issue control and hazard request
`timescale 1ns/1ps
`default_nettype none

`include "decode_macros.svh"

module issue_control
	import decode_ctrl_pkg::*;
(
	input  logic                   flush,
	input  logic                   id_valid,
	input  logic                   inst_present,
	input  logic [`XLEN-1:0]       id_inst,
	input  logic                   is_fence,
	input  csr_op_t                csr_op,
	input  logic                   csr_uses_imm,
	input  logic                   rf_we_raw,
	input  logic                   mem_we_raw,
	input  logic                   mem_re_raw,
	input  logic                   branch_raw,
	input  logic                   jump_raw,
	input  logic                   uses_rs2,
	input  logic                   lsu_mem_re,
	input  logic [`REG_ADDR_W-1:0] lsu_rd,
	output logic                   ex_valid,
	output logic [`XLEN-1:0]       ex_inst,
	output logic                   ex_rf_we,
	output logic                   ex_mem_we,
	output logic                   ex_mem_re,
	output logic                   ex_branch,
	output logic                   ex_jump,
	output logic                   ex_csr_we,
	output logic                   ex_csr_re,
	output logic                   hazard
);
	logic [`REG_ADDR_W-1:0] rs1;
	logic [`REG_ADDR_W-1:0] rs2;
	logic [`REG_ADDR_W-1:0] rd;
	logic                   csr_write;
	logic                   csr_modify;
	logic                   csr_we;
	logic                   csr_re;
	logic                   rs1_match;
	logic                   rs2_match;

	assign rs1 = id_inst[19:15];
	assign rs2 = id_inst[24:20];
	assign rd  = id_inst[11:7];

	// set/clear with x0 or a zero uimm must not write the csr
	assign csr_write  = (csr_op == CSR_WRITE);
	assign csr_modify = (csr_op == CSR_SET) || (csr_op == CSR_CLEAR);
	assign csr_we     = csr_write || (csr_modify && rs1 != '0);
	assign csr_re     = csr_modify || (csr_write && rd != '0);

	assign ex_valid  = !flush && id_valid && inst_present;
	assign ex_inst   = (flush || is_fence) ? `INST_NOP : id_inst;
	assign ex_rf_we  = !flush && rf_we_raw;
	assign ex_mem_we = !flush && mem_we_raw;
	assign ex_mem_re = !flush && mem_re_raw;
	assign ex_branch = !flush && branch_raw;
	assign ex_jump   = !flush && jump_raw;
	assign ex_csr_we = !flush && csr_we;
	assign ex_csr_re = !flush && csr_re;

	// uimm forms carry no rs1, a load to x0 never conflicts
	assign rs1_match = (lsu_rd == rs1) && !csr_uses_imm;
	assign rs2_match = (lsu_rd == rs2) && uses_rs2;

	// also stall while the memory word is still missing
	assign hazard = (lsu_mem_re && lsu_rd != '0 && (rs1_match || rs2_match)) ||
	                (id_valid && !inst_present);

	always_comb begin
		a_flush_quiet: assert final (!flush || !(ex_valid || ex_rf_we || ex_mem_we ||
			ex_mem_re || ex_branch || ex_jump || ex_csr_we || ex_csr_re))
		else $error("enable leaked through a flush");
	end

endmodule

`default_nettype wire

// ==== hdl/rv_isa_pkg.sv ====
// rv32i instruction encodings
`default_nettype none

`include "decode_macros.svh"

package rv_isa_pkg;

	// major opcode, instruction bits 6..2
	typedef enum logic [`OPCODE_W-1:0] {
		OPC_LOAD     = 5'b00000,
		OPC_MISC_MEM = 5'b00011,
		OPC_OP_IMM   = 5'b00100,
		OPC_AUIPC    = 5'b00101,
		OPC_STORE    = 5'b01000,
		OPC_OP       = 5'b01100,
		OPC_LUI      = 5'b01101,
		OPC_BRANCH   = 5'b11000,
		OPC_JALR     = 5'b11001,
		OPC_JAL      = 5'b11011,
		OPC_SYSTEM   = 5'b11100
	} opcode_t;

	typedef logic [`FUNCT3_W-1:0] funct3_t;

	// branch conditions
	localparam funct3_t F3_BEQ  = 3'b000;
	localparam funct3_t F3_BNE  = 3'b001;
	localparam funct3_t F3_BLT  = 3'b100;
	localparam funct3_t F3_BGE  = 3'b101;
	localparam funct3_t F3_BLTU = 3'b110;
	localparam funct3_t F3_BGEU = 3'b111;

	// alu operations, shared by op and op_imm
	localparam funct3_t F3_ADD  = 3'b000;
	localparam funct3_t F3_SLL  = 3'b001;
	localparam funct3_t F3_SLT  = 3'b010;
	localparam funct3_t F3_SLTU = 3'b011;
	localparam funct3_t F3_XOR  = 3'b100;
	localparam funct3_t F3_SR   = 3'b101;
	localparam funct3_t F3_OR   = 3'b110;
	localparam funct3_t F3_AND  = 3'b111;

	// load and store sizes
	localparam funct3_t F3_B  = 3'b000;
	localparam funct3_t F3_H  = 3'b001;
	localparam funct3_t F3_W  = 3'b010;
	localparam funct3_t F3_BU = 3'b100;
	localparam funct3_t F3_HU = 3'b101;

	localparam funct3_t F3_FENCE = 3'b000;

	// sub and sra/srai
	localparam logic [`FUNCT7_W-1:0] FUNCT7_ALT = 7'b0100000;

endpackage

`default_nettype wire

// ==== project.f ====
+incdir+hdl
+incdir+tests
hdl/rv_isa_pkg.sv
hdl/decode_ctrl_pkg.sv
hdl/fetch_hold_buffer.sv
hdl/inst_classifier.sv
hdl/imm_generator.sv
hdl/issue_control.sv
hdl/decode_stage.sv
tests/decode_stage_tb.sv

// ==== tests/decode_input.txt ====
# name pc inst stall_cycles flush lsu_mem_re lsu_rd alu_op imm mem_size rd_src en hazard ex_inst
# en bits msb first: rf_we mem_we mem_re csr_we csr_re branch jump valid
# alu_op, mem_size and rd_src hold the enum values of decode_ctrl_pkg
addi       00001000 00510093 0 0 0 00 0 00000005 0 0 81 0 00510093
sltiu      00001004 fff23193 0 0 0 00 4 ffffffff 0 0 81 0 fff23193
slli       00001008 00409093 0 0 0 00 2 00000004 0 0 81 0 00409093
srai       0000100c 40335293 0 0 0 00 7 00000403 0 0 81 0 40335293
sub        00001010 409403b3 0 0 0 00 1 40940000 0 0 81 0 409403b3
xor        00001014 00c5c533 0 0 0 00 5 00c5c000 0 0 81 0 00c5c533
and        00001018 00f776b3 0 0 0 00 9 00f77000 0 0 81 0 00f776b3
srl        0000101c 0041d133 0 0 0 00 6 0041d000 0 0 81 0 0041d133
lb         00001020 ffc10083 0 0 0 00 0 fffffffc 0 0 a1 0 ffc10083
lhu        00001024 00625183 0 0 0 00 0 00000006 3 0 a1 0 00625183
lw         00001028 00832283 0 0 0 00 0 00000008 4 0 a1 0 00832283
sb         0000102c 007401a3 0 0 0 00 0 00000003 0 0 41 0 007401a3
sw         00001030 fe952c23 0 0 0 00 0 fffffff8 4 0 41 0 fe952c23
beq        00001034 00208863 0 0 0 00 a 00000010 0 0 05 0 00208863
bgeu       00001038 fe41fce3 0 0 0 00 d fffffff8 0 0 05 0 fe41fce3
jal        0000103c 001000ef 0 0 0 00 0 00000800 0 2 83 0 001000ef
jalr       00001040 ff4302e7 0 0 0 00 0 fffffff4 0 2 83 0 ff4302e7
lui        00001044 123453b7 0 0 0 00 0 12345000 0 1 81 0 123453b7
auipc      00001048 fffff417 0 0 0 00 0 fffff000 0 1 81 0 fffff417
csrrs_x0   0000104c 300020f3 0 0 0 00 8 00000000 0 0 89 0 300020f3
csrrw_rd0  00001050 34029073 0 0 0 00 0 00000005 0 0 91 0 34029073
csrrci     00001054 3002f173 0 0 0 00 9 fffffffa 0 0 99 0 3002f173
flush_lw   00001058 00832283 0 1 0 00 0 00000008 4 0 00 0 00000013
fence      0000105c 0ff0000f 0 0 0 00 0 0ff00000 0 0 01 0 00000013
luse_rs1   00001060 00510093 0 0 1 02 0 00000005 0 0 81 1 00510093
luse_rs2   00001064 00628233 0 0 1 06 0 00628000 0 0 81 1 00628233
rs2_imm    00001068 00218093 0 0 1 02 0 00000002 0 0 81 0 00218093
stall_sub  0000106c 409403b3 2 0 0 00 1 40940000 0 0 81 0 409403b3
stall_csr  00001070 3002f173 2 0 0 00 9 fffffffa 0 0 99 0 3002f173

// ==== tests/decode_checks.svh ====
// decode testbench compare tasks
`ifndef DECODE_CHECKS_SVH
`define DECODE_CHECKS_SVH

int pass_count   = 0;
int fail_count   = 0;
int test_errors  = 0;
int total_errors = 0;

task automatic note_mismatch();
	test_errors++;
	total_errors++;
endtask

task automatic check_alu_op(input string test, input string field,
		input alu_op_t exp, input alu_op_t act);
	if (act !== exp) begin
		$display("FAIL %s %s: expected %s (%0d), actual %s (%0d)",
			test, field, exp.name(), exp, act.name(), act);
		note_mismatch();
	end
endtask

task automatic check_mem_size(input string test, input string field,
		input mem_size_t exp, input mem_size_t act);
	if (act !== exp) begin
		$display("FAIL %s %s: expected %s (%0d), actual %s (%0d)",
			test, field, exp.name(), exp, act.name(), act);
		note_mismatch();
	end
endtask

task automatic check_rd_src(input string test, input string field,
		input rd_src_t exp, input rd_src_t act);
	if (act !== exp) begin
		$display("FAIL %s %s: expected %s (%0d), actual %s (%0d)",
			test, field, exp.name(), exp, act.name(), act);
		note_mismatch();
	end
endtask

task automatic check_word(input string test, input string field,
		input logic [`XLEN-1:0] exp, input logic [`XLEN-1:0] act);
	if (act !== exp) begin
		$display("FAIL %s %s: expected %08h, actual %08h", test, field, exp, act);
		note_mismatch();
	end
endtask

task automatic check_reg_idx(input string test, input string field,
		input logic [`REG_ADDR_W-1:0] exp, input logic [`REG_ADDR_W-1:0] act);
	if (act !== exp) begin
		$display("FAIL %s %s: expected x%0d, actual x%0d", test, field, exp, act);
		note_mismatch();
	end
endtask

task automatic check_csr_addr(input string test, input string field,
		input logic [`CSR_ADDR_W-1:0] exp, input logic [`CSR_ADDR_W-1:0] act);
	if (act !== exp) begin
		$display("FAIL %s %s: expected %03h, actual %03h", test, field, exp, act);
		note_mismatch();
	end
endtask

task automatic check_bit(input string test, input string field,
		input logic exp, input logic act);
	if (act !== exp) begin
		$display("FAIL %s %s: expected %b, actual %b", test, field, exp, act);
		note_mismatch();
	end
endtask

// one line per finished test
task automatic close_test(input string test);
	if (test_errors == 0) begin
		pass_count++;
		$display("[pass] %s", test);
	end else begin
		fail_count++;
		$display("[fail] %s, %0d mismatches", test, test_errors);
	end
	test_errors = 0;
endtask

`endif

// ==== tests/decode_stage_tb.sv ====
// decode stage testbench
`timescale 1ns/1ps
`default_nettype none

`include "decode_macros.svh"

module decode_stage_tb
	import decode_ctrl_pkg::*;
();
	localparam int MAX_VEC = 64;
	localparam int FIELDS  = 14;

	logic                   clk;
	logic                   rstn;
	logic                   stall;
	logic                   flush;
	logic                   if_valid;
	logic [`XLEN-1:0]       if_pc;
	logic [`XLEN-1:0]       if_pc_plus;
	logic                   imem_valid;
	logic [`XLEN-1:0]       imem_data;
	logic                   lsu_mem_re;
	logic [`REG_ADDR_W-1:0] lsu_rd;
	logic                   ex_valid;
	logic [`XLEN-1:0]       ex_inst;
	logic                   ex_rf_we;
	logic                   ex_mem_we;
	logic                   ex_mem_re;
	logic                   ex_branch;
	logic                   ex_jump;
	logic                   ex_csr_we;
	logic                   ex_csr_re;
	logic [`XLEN-1:0]       ex_pc;
	logic [`XLEN-1:0]       ex_pc_plus;
	logic [`REG_ADDR_W-1:0] ex_rs1;
	logic [`REG_ADDR_W-1:0] ex_rs2;
	logic [`REG_ADDR_W-1:0] ex_rd;
	logic [`CSR_ADDR_W-1:0] ex_csr_addr;
	logic [`XLEN-1:0]       ex_imm;
	alu_op_t                ex_alu_op;
	logic                   ex_alu_op2_imm;
	rd_src_t                ex_rd_src;
	logic                   ex_rd_from_mem;
	mem_size_t              ex_mem_size;
	logic                   ex_jalr;
	logic                   hazard;

	// one entry per line of the vector file
	string       vec_name [MAX_VEC];
	logic [31:0] vec_pc [MAX_VEC];
	logic [31:0] vec_inst [MAX_VEC];
	logic [31:0] vec_stall [MAX_VEC];
	logic [31:0] vec_flush [MAX_VEC];
	logic [31:0] vec_lre [MAX_VEC];
	logic [31:0] vec_lrd [MAX_VEC];
	logic [31:0] vec_alu [MAX_VEC];
	logic [31:0] vec_imm [MAX_VEC];
	logic [31:0] vec_size [MAX_VEC];
	logic [31:0] vec_rdsrc [MAX_VEC];
	logic [31:0] vec_en [MAX_VEC];
	logic [31:0] vec_haz [MAX_VEC];
	logic [31:0] vec_exinst [MAX_VEC];
	int          num_vec     = 0;
	int          cycle_count = 0;
	int          cycle_limit = 50;

	`include "decode_checks.svh"

	decode_stage decode_stage_i (.*);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= cycle_limit) begin
			$display("timeout: run still busy after %0d cycles", cycle_count);
			$display("TEST FAILED");
			$finish;
		end
	end

	task automatic load_vectors();
		int               fd;
		int               n;
		logic [8*256-1:0] line_buf;
		string            t_name;
		logic [31:0]      t_pc, t_inst, t_stall, t_flush, t_lre, t_lrd, t_alu;
		logic [31:0]      t_imm, t_size, t_rdsrc, t_en, t_haz, t_exinst;
		fd = $fopen("tests/decode_input.txt", "r");
		if (fd == 0) begin
			$display("cannot open tests/decode_input.txt");
		end else begin
			line_buf = '0;
			// comment and blank lines never fill every field
			while ($fgets(line_buf, fd) > 0) begin
				n = $sscanf(line_buf, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h",
					t_name, t_pc, t_inst, t_stall, t_flush, t_lre, t_lrd, t_alu,
					t_imm, t_size, t_rdsrc, t_en, t_haz, t_exinst);
				if (n == FIELDS && num_vec < MAX_VEC) begin
					vec_name[num_vec]   = t_name;
					vec_pc[num_vec]     = t_pc;
					vec_inst[num_vec]   = t_inst;
					vec_stall[num_vec]  = t_stall;
					vec_flush[num_vec]  = t_flush;
					vec_lre[num_vec]    = t_lre;
					vec_lrd[num_vec]    = t_lrd;
					vec_alu[num_vec]    = t_alu;
					vec_imm[num_vec]    = t_imm;
					vec_size[num_vec]   = t_size;
					vec_rdsrc[num_vec]  = t_rdsrc;
					vec_en[num_vec]     = t_en;
					vec_haz[num_vec]    = t_haz;
					vec_exinst[num_vec] = t_exinst;
					num_vec++;
				end
				line_buf = '0;
			end
			$fclose(fd);
		end
	endtask

	task automatic check_reset_state();
		check_bit("reset", "valid", 1'b0, ex_valid);
		check_bit("reset", "rf_we", 1'b0, ex_rf_we);
		check_bit("reset", "mem_we", 1'b0, ex_mem_we);
		check_bit("reset", "mem_re", 1'b0, ex_mem_re);
		check_bit("reset", "csr_we", 1'b0, ex_csr_we);
		check_bit("reset", "csr_re", 1'b0, ex_csr_re);
		check_bit("reset", "branch", 1'b0, ex_branch);
		check_bit("reset", "jump", 1'b0, ex_jump);
		check_bit("reset", "hazard", 1'b0, hazard);
		check_word("reset", "pc", '0, ex_pc);
		check_word("reset", "pc_plus", '0, ex_pc_plus);
		close_test("reset");
	endtask

	task automatic compare_outputs(input int i);
		string       name;
		logic [31:0] inst;
		logic [6:0]  opc;
		logic        exp_imm_op;
		name = vec_name[i];
		inst = vec_inst[i];
		opc  = inst[6:0];
		// jalr, loads, stores, op-imm and csr take the immediate as operand 2
		exp_imm_op = (opc == 7'h67) || (opc == 7'h03) || (opc == 7'h23) ||
			(opc == 7'h13) || (opc == 7'h73 && inst[14:12] != 3'b000);
		check_alu_op(name, "alu_op", alu_op_t'(vec_alu[i][3:0]), ex_alu_op);
		check_word(name, "imm", vec_imm[i], ex_imm);
		check_mem_size(name, "mem_size", mem_size_t'(vec_size[i][2:0]), ex_mem_size);
		check_rd_src(name, "rd_src", rd_src_t'(vec_rdsrc[i][1:0]), ex_rd_src);
		check_bit(name, "rf_we", vec_en[i][7], ex_rf_we);
		check_bit(name, "mem_we", vec_en[i][6], ex_mem_we);
		check_bit(name, "mem_re", vec_en[i][5], ex_mem_re);
		check_bit(name, "csr_we", vec_en[i][4], ex_csr_we);
		check_bit(name, "csr_re", vec_en[i][3], ex_csr_re);
		check_bit(name, "branch", vec_en[i][2], ex_branch);
		check_bit(name, "jump", vec_en[i][1], ex_jump);
		check_bit(name, "valid", vec_en[i][0], ex_valid);
		check_bit(name, "hazard", vec_haz[i][0], hazard);
		check_word(name, "ex_inst", vec_exinst[i], ex_inst);
		check_word(name, "pc", vec_pc[i], ex_pc);
		check_word(name, "pc_plus", vec_pc[i] + 32'd4, ex_pc_plus);
		check_bit(name, "alu_op2_imm", exp_imm_op, ex_alu_op2_imm);
		check_bit(name, "rd_from_mem", opc == 7'h03, ex_rd_from_mem);
		check_bit(name, "jalr", opc == 7'h67, ex_jalr);
		// rv32 register and csr field positions
		check_reg_idx(name, "rs1", inst[19:15], ex_rs1);
		check_reg_idx(name, "rs2", inst[24:20], ex_rs2);
		check_reg_idx(name, "rd", inst[11:7], ex_rd);
		check_csr_addr(name, "csr_addr", inst[31:20], ex_csr_addr);
	endtask

	task automatic run_vector(input int i);
		@(posedge clk);
		if_valid   <= 1'b1;
		if_pc      <= vec_pc[i];
		if_pc_plus <= vec_pc[i] + 32'd4;
		imem_valid <= 1'b0;
		stall      <= 1'b0;
		flush      <= 1'b0;
		lsu_mem_re <= 1'b0;
		// memory word one cycle behind the fetch beat
		@(posedge clk);
		if_valid   <= 1'b0;
		imem_valid <= 1'b1;
		imem_data  <= vec_inst[i];
		flush      <= vec_flush[i][0];
		lsu_mem_re <= vec_lre[i][0];
		lsu_rd     <= vec_lrd[i][`REG_ADDR_W-1:0];
		stall      <= (vec_stall[i] != 0);
		if (vec_stall[i] != 0) begin
			// response gone, only the held copy is left
			@(posedge clk);
			imem_valid <= 1'b0;
			imem_data  <= ~vec_inst[i];
			repeat (vec_stall[i] - 1) @(posedge clk);
			stall <= 1'b0;
		end
		@(negedge clk);
		compare_outputs(i);
		close_test(vec_name[i]);
	endtask

	initial begin
		rstn       = 1'b0;
		stall      = 1'b0;
		flush      = 1'b0;
		if_valid   = 1'b0;
		if_pc      = '0;
		if_pc_plus = '0;
		imem_valid = 1'b0;
		imem_data  = '0;
		lsu_mem_re = 1'b0;
		lsu_rd     = '0;
		load_vectors();
		if (num_vec == 0) begin
			$display("no test vectors loaded, nothing to run");
			$display("TEST FAILED");
			$finish;
		end else begin
			// at most four edges per vector, the rest is margin
			cycle_limit = num_vec * 6 + 50;
			repeat (7) @(posedge clk);
			@(negedge clk);
			check_reset_state();
			@(posedge clk);
			rstn <= 1'b1;
			for (int i = 0; i < num_vec; i++) begin
				run_vector(i);
			end
			$display("tests %0d, passed %0d, failed %0d, mismatches %0d",
				pass_count + fail_count, pass_count, fail_count, total_errors);
			if (fail_count == 0) begin
				$display("TEST OK");
			end else begin
				$display("TEST FAILED");
			end
			$finish;
		end
	end

endmodule

`default_nettype wire
